// File: src/vga_pkg.sv
/* Shared definitions for the SVGA 800x600 test-pattern pipeline
   Counter and colour widths, timing constants, colour words
   and the horizontal phase type of the timing generator */

package vga_pkg;

  // Counter and pixel widths
  localparam int cnt_w = 11;
  localparam int rgb_w = 12;

  // Horizontal timing, in pixels
  localparam logic [cnt_w-1:0] h_active     = 11'd800;
  localparam logic [cnt_w-1:0] h_sync_start = 11'd840;
  // Sync end is exclusive
  localparam logic [cnt_w-1:0] h_sync_end   = 11'd968;
  localparam logic [cnt_w-1:0] h_total      = 11'd1056;

  // Vertical timing, in lines
  localparam logic [cnt_w-1:0] v_active     = 11'd600;
  localparam logic [cnt_w-1:0] v_sync_start = 11'd601;
  // Sync end is exclusive
  localparam logic [cnt_w-1:0] v_sync_end   = 11'd605;
  localparam logic [cnt_w-1:0] v_total      = 11'd628;

  // Colour words, 4 bits per channel, R in the top nibble
  localparam logic [rgb_w-1:0] col_black  = 12'h000;
  // Top edge, yellow
  localparam logic [rgb_w-1:0] col_top    = 12'hff0;
  // Bottom edge, red
  localparam logic [rgb_w-1:0] col_bottom = 12'hf00;
  // Left edge, green
  localparam logic [rgb_w-1:0] col_left   = 12'h0f0;
  // Right edge, blue
  localparam logic [rgb_w-1:0] col_right  = 12'h00f;
  // Orange initials
  localparam logic [rgb_w-1:0] col_letter = 12'hc61;
  // Grey background
  localparam logic [rgb_w-1:0] col_fill   = 12'h888;

  // Horizontal regions of one line, in scan order
  typedef enum logic [1:0] {
    ph_active,
    ph_front,
    ph_sync,
    ph_back
  } h_phase_t;

endpackage

// File: src/vga_if.sv
/* Pixel stream bundle between pipeline stages
   Counters, syncs, blanking flags and colour, with source and sink views */

`timescale 1ns/1ps

interface vga_if;

  // Pixel position
  logic [vga_pkg::cnt_w-1:0] hcount;
  logic [vga_pkg::cnt_w-1:0] vcount;

  // Sync pulses, active high
  logic hsync;
  logic vsync;

  // Blanking flags
  logic hblnk;
  logic vblnk;

  // Pixel colour
  logic [vga_pkg::rgb_w-1:0] rgb;

  // Stage that produces the stream
  modport src (
    output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

  // Stage that consumes the stream
  modport snk (
    input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

endinterface

// File: src/vga_timing.sv
/* SVGA 800x600 timing generator
   Horizontal and vertical counters, a horizontal phase FSM,
   registered vertical sync and blanking */

`timescale 1ns/1ps

module vga_timing (
  input  logic pclk,
  input  logic rst,
  vga_if.src   tim
);

  // Current counters
  logic [vga_pkg::cnt_w-1:0] hcount_q;
  logic [vga_pkg::cnt_w-1:0] vcount_q;

  // Counter values for the next pixel
  logic [vga_pkg::cnt_w-1:0] hcount_nxt;
  logic [vga_pkg::cnt_w-1:0] vcount_nxt;
  logic                      h_wrap;
  logic                      v_wrap;

  // Horizontal region of the current pixel
  vga_pkg::h_phase_t phase_q;
  vga_pkg::h_phase_t phase_nxt;

  // Vertical flags, kept in step with vcount_q
  logic vsync_q;
  logic vblnk_q;

  // Next counter values
  always_comb begin
    h_wrap = (hcount_q == vga_pkg::h_total - 1'b1);
    v_wrap = (vcount_q == vga_pkg::v_total - 1'b1);

    if (h_wrap) begin
      hcount_nxt = '0;
    end else begin
      hcount_nxt = hcount_q + 1'b1;
    end

    // Line count only steps at the end of a line
    if (!h_wrap) begin
      vcount_nxt = vcount_q;
    end else if (v_wrap) begin
      vcount_nxt = '0;
    end else begin
      vcount_nxt = vcount_q + 1'b1;
    end
  end

  // Phase changes at the first pixel of each region
  always_comb begin
    phase_nxt = phase_q;
    case (hcount_nxt)
      '0:                     phase_nxt = vga_pkg::ph_active;
      vga_pkg::h_active:      phase_nxt = vga_pkg::ph_front;
      vga_pkg::h_sync_start:  phase_nxt = vga_pkg::ph_sync;
      vga_pkg::h_sync_end:    phase_nxt = vga_pkg::ph_back;
      default:                phase_nxt = phase_q;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount_q <= '0;
      vcount_q <= '0;
      // Pixel (0,0) sits in the active region
      phase_q  <= vga_pkg::ph_active;
      vsync_q  <= 1'b0;
      vblnk_q  <= 1'b0;
    end else begin
      hcount_q <= hcount_nxt;
      vcount_q <= vcount_nxt;
      phase_q  <= phase_nxt;
      // Compared on the next count so the flags land with it
      vsync_q  <= (vcount_nxt >= vga_pkg::v_sync_start) &&
                  (vcount_nxt <  vga_pkg::v_sync_end);
      vblnk_q  <= (vcount_nxt >= vga_pkg::v_active);
    end
  end

  // Stream outputs
  assign tim.hcount = hcount_q;
  assign tim.vcount = vcount_q;
  // Horizontal flags decoded from the phase register
  assign tim.hsync  = (phase_q == vga_pkg::ph_sync);
  assign tim.hblnk  = (phase_q != vga_pkg::ph_active);
  assign tim.vsync  = vsync_q;
  assign tim.vblnk  = vblnk_q;
  // No colour yet at the generator
  assign tim.rgb    = vga_pkg::col_black;

endmodule

// File: src/draw_background.sv
/* Background renderer stage
   Four-colour frame border, two orange initials and grey fill,
   with the timing signals delayed by one cycle */

`timescale 1ns/1ps

module draw_background (
  input  logic pclk,
  input  logic rst,
  vga_if.snk   in,
  vga_if.src   out
);

  // Last visible row and column
  localparam logic [vga_pkg::cnt_w-1:0] last_row = vga_pkg::v_active - 1'b1;
  localparam logic [vga_pkg::cnt_w-1:0] last_col = vga_pkg::h_active - 1'b1;

  // Letter bar hits for the incoming pixel
  logic in_hbar;
  logic in_j_stem;
  logic in_j_hook;
  logic in_c_stem;
  logic in_letter;

  logic [vga_pkg::rgb_w-1:0] rgb_nxt;

  // Letter geometry, all bounds inclusive
  always_comb begin
    // Top and bottom bars of both letters
    in_hbar   = ((in.vcount >= 11'd75  && in.vcount <= 11'd125) ||
                 (in.vcount >= 11'd475 && in.vcount <= 11'd525)) &&
                ((in.hcount >= 11'd125 && in.hcount <= 11'd375) ||
                 (in.hcount >= 11'd425 && in.hcount <= 11'd675));
    // Right-hand stem of the J
    in_j_stem = (in.hcount >= 11'd325 && in.hcount <= 11'd375) &&
                (in.vcount >= 11'd125 && in.vcount <= 11'd475);
    // Short hook at the lower left of the J
    in_j_hook = (in.hcount >= 11'd125 && in.hcount <= 11'd175) &&
                (in.vcount >= 11'd425 && in.vcount <= 11'd475);
    // Left-hand stem of the C
    in_c_stem = (in.hcount >= 11'd425 && in.hcount <= 11'd475) &&
                (in.vcount >= 11'd125 && in.vcount <= 11'd475);
    in_letter = in_hbar || in_j_stem || in_j_hook || in_c_stem;
  end

  // Colour priority, first match wins
  always_comb begin
    if (in.hblnk || in.vblnk) begin
      rgb_nxt = vga_pkg::col_black;
    end else if (in.vcount == '0) begin
      // Top row wins over the side edges in the corners
      rgb_nxt = vga_pkg::col_top;
    end else if (in.vcount == last_row) begin
      rgb_nxt = vga_pkg::col_bottom;
    end else if (in.hcount == '0) begin
      rgb_nxt = vga_pkg::col_left;
    end else if (in.hcount == last_col) begin
      rgb_nxt = vga_pkg::col_right;
    end else if (in_letter) begin
      rgb_nxt = vga_pkg::col_letter;
    end else begin
      rgb_nxt = vga_pkg::col_fill;
    end
  end

  // Colour and timing registered together to stay aligned
  always_ff @(posedge pclk) begin
    if (rst) begin
      out.hcount <= '0;
      out.vcount <= '0;
      out.hsync  <= 1'b0;
      out.vsync  <= 1'b0;
      out.hblnk  <= 1'b0;
      out.vblnk  <= 1'b0;
      out.rgb    <= '0;
    end else begin
      out.hcount <= in.hcount;
      out.vcount <= in.vcount;
      out.hsync  <= in.hsync;
      out.vsync  <= in.vsync;
      out.hblnk  <= in.hblnk;
      out.vblnk  <= in.vblnk;
      // Incoming rgb is replaced entirely
      out.rgb    <= rgb_nxt;
    end
  end

endmodule

// File: src/draw_rect.sv
/* Rectangle overlay stage
   Paints one solid rectangle over the background stream,
   with all timing signals delayed by one cycle */

`timescale 1ns/1ps

module draw_rect #(
  parameter int unsigned               rect_x     = 200,
  parameter int unsigned               rect_y     = 250,
  parameter int unsigned               rect_w     = 100,
  parameter int unsigned               rect_h     = 60,
  parameter logic [vga_pkg::rgb_w-1:0] rect_color = 12'h0ac
) (
  input  logic pclk,
  input  logic rst,
  vga_if.snk   in,
  vga_if.src   out
);

  // Last column and row inside the rectangle
  localparam int unsigned rect_x_last = rect_x + rect_w - 1;
  localparam int unsigned rect_y_last = rect_y + rect_h - 1;

  logic                      in_rect;
  logic [vga_pkg::rgb_w-1:0] rgb_nxt;

  // Hit test, only on visible pixels
  always_comb begin
    in_rect = !in.hblnk && !in.vblnk &&
              (in.hcount >= rect_x) && (in.hcount <= rect_x_last) &&
              (in.vcount >= rect_y) && (in.vcount <= rect_y_last);
    // Background shows through outside the rectangle
    if (in_rect) begin
      rgb_nxt = rect_color;
    end else begin
      rgb_nxt = in.rgb;
    end
  end

  // One register stage for the whole bundle
  always_ff @(posedge pclk) begin
    if (rst) begin
      out.hcount <= '0;
      out.vcount <= '0;
      out.hsync  <= 1'b0;
      out.vsync  <= 1'b0;
      out.hblnk  <= 1'b0;
      out.vblnk  <= 1'b0;
      out.rgb    <= '0;
    end else begin
      out.hcount <= in.hcount;
      out.vcount <= in.vcount;
      out.hsync  <= in.hsync;
      out.vsync  <= in.vsync;
      out.hblnk  <= in.hblnk;
      out.vblnk  <= in.vblnk;
      out.rgb    <= rgb_nxt;
    end
  end

endmodule

// File: src/vga_top.sv
/* Top level of the test-pattern pipeline
   Timing generator, background renderer and rectangle overlay,
   joined by interface bundles and exposed as plain ports */

`timescale 1ns/1ps

module vga_top #(
  parameter int unsigned               rect_x     = 200,
  parameter int unsigned               rect_y     = 250,
  parameter int unsigned               rect_w     = 100,
  parameter int unsigned               rect_h     = 60,
  parameter logic [vga_pkg::rgb_w-1:0] rect_color = 12'h0ac
) (
  input  logic                      pclk,
  input  logic                      rst,
  output logic [vga_pkg::cnt_w-1:0] hcount,
  output logic [vga_pkg::cnt_w-1:0] vcount,
  output logic                      hsync,
  output logic                      vsync,
  output logic                      hblnk,
  output logic                      vblnk,
  output logic [vga_pkg::rgb_w-1:0] rgb
);

  // Stream after each stage
  vga_if tim ();
  vga_if bg ();
  vga_if out ();

  // Counters, syncs and blanking
  vga_timing i_timing (
    .pclk (pclk),
    .rst  (rst),
    .tim  (tim)
  );

  // Border, initials and fill, one cycle behind the generator
  draw_background i_background (
    .pclk (pclk),
    .rst  (rst),
    .in   (tim),
    .out  (bg)
  );

  // Rectangle on top, two cycles behind the generator
  draw_rect #(
    .rect_x     (rect_x),
    .rect_y     (rect_y),
    .rect_w     (rect_w),
    .rect_h     (rect_h),
    .rect_color (rect_color)
  ) i_rect (
    .pclk (pclk),
    .rst  (rst),
    .in   (bg),
    .out  (out)
  );

  // Final stream to the pins
  assign hcount = out.hcount;
  assign vcount = out.vcount;
  assign hsync  = out.hsync;
  assign vsync  = out.vsync;
  assign hblnk  = out.hblnk;
  assign vblnk  = out.vblnk;
  assign rgb    = out.rgb;

endmodule

// File: bench/vga_tb.sv
/* Testbench for the SVGA test-pattern pipeline
   Clock and reset, probe list reader, per-cycle timing and colour
   checks, one report line per test and a closing count line */

`timescale 1ns/1ps

module vga_tb;

  // Frame geometry as plain integers
  localparam int h_tot     = int'(vga_pkg::h_total);
  localparam int v_tot     = int'(vga_pkg::v_total);
  localparam int frame_len = h_tot * v_tot;
  // Reset, pipeline fill, then twice the one-frame run as margin
  localparam int timeout_cycles = 16 + 2 + 2 * frame_len;

  logic                      pclk;
  logic                      rst;
  logic [vga_pkg::cnt_w-1:0] hcount;
  logic [vga_pkg::cnt_w-1:0] vcount;
  logic                      hsync;
  logic                      vsync;
  logic                      hblnk;
  logic                      vblnk;
  logic [vga_pkg::rgb_w-1:0] rgb;

  // Probe table loaded from the stimulus file
  logic [vga_pkg::cnt_w-1:0] probe_h[$];
  logic [vga_pkg::cnt_w-1:0] probe_v[$];
  logic [vga_pkg::rgb_w-1:0] probe_rgb[$];
  bit                        probe_hit[$];
  int                        probe_errs[$];

  // Expected raster position of the current output pixel
  logic [vga_pkg::cnt_w-1:0] exp_h;
  logic [vga_pkg::cnt_w-1:0] exp_v;

  // Error counts per rule and overall tallies
  int err_reset;
  int err_count;
  int err_sync;
  int err_blank;
  int tests_run;
  int tests_failed;
  int error_total;
  int cycle_count;

  vga_top i_dut (
    .pclk   (pclk),
    .rst    (rst),
    .hcount (hcount),
    .vcount (vcount),
    .hsync  (hsync),
    .vsync  (vsync),
    .hblnk  (hblnk),
    .vblnk  (vblnk),
    .rgb    (rgb)
  );

  // 100 ns pixel clock
  always #50 pclk = ~pclk;

  // Watchdog on the whole run
  always @(posedge pclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("ERROR: run did not complete within %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic int check_value(input string name, input logic [31:0] expected,
                                     input logic [31:0] actual);
    int bad;
    bad = 0;
    assert (actual === expected) else begin
      $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
      bad = 1;
    end
    return bad;
  endfunction

  function automatic int check_true(input bit cond, input string what);
    int bad;
    bad = 0;
    assert (cond) else begin
      $display("ERROR t=%0t %s", $time, what);
      bad = 1;
    end
    return bad;
  endfunction

  // All outputs held at zero
  function automatic int check_idle();
    int bad;
    bad = check_value("hcount", 32'(0), 32'(hcount));
    bad += check_value("vcount", 32'(0), 32'(vcount));
    bad += check_value("hsync", 32'(0), 32'(hsync));
    bad += check_value("vsync", 32'(0), 32'(vsync));
    bad += check_value("hblnk", 32'(0), 32'(hblnk));
    bad += check_value("vblnk", 32'(0), 32'(vblnk));
    bad += check_value("rgb", 32'(0), 32'(rgb));
    return bad;
  endfunction

  task automatic report_test(input string name, input int errs);
    tests_run++;
    error_total += errs;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errs);
    end
  endtask

  task automatic load_probes();
    int                        fd;
    int                        n;
    string                     line;
    logic [vga_pkg::cnt_w-1:0] sh;
    logic [vga_pkg::cnt_w-1:0] sv;
    logic [vga_pkg::rgb_w-1:0] sc;
    fd = $fopen("bench/vga_stimulus.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the probe file bench/vga_stimulus.txt");
      error_total++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comment lines, keep h v rgb triples
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%d %d %h", sh, sv, sc);
          if (n == 3) begin
            probe_h.push_back(sh);
            probe_v.push_back(sv);
            probe_rgb.push_back(sc);
            probe_hit.push_back(1'b0);
            probe_errs.push_back(0);
          end
        end
      end
      $fclose(fd);
    end
    error_total += check_true(probe_h.size() > 0, "no probes were loaded");
  endtask

  // All per-cycle rules on one output pixel
  task automatic check_pixel();
    int k;
    err_count += check_value("hcount", 32'(exp_h), 32'(hcount));
    err_count += check_value("vcount", 32'(exp_v), 32'(vcount));
    err_sync += check_true(hcount < vga_pkg::h_total, "hcount reached the line length");
    err_sync += check_true(vcount < vga_pkg::v_total, "vcount reached the frame length");
    err_sync += check_value("hsync", 32'(hcount >= vga_pkg::h_sync_start &&
                                          hcount < vga_pkg::h_sync_end), 32'(hsync));
    err_sync += check_value("hblnk", 32'(hcount >= vga_pkg::h_active), 32'(hblnk));
    err_sync += check_value("vsync", 32'(vcount >= vga_pkg::v_sync_start &&
                                          vcount < vga_pkg::v_sync_end), 32'(vsync));
    err_sync += check_value("vblnk", 32'(vcount >= vga_pkg::v_active), 32'(vblnk));
    // Nothing but black while blanked
    if (hblnk || vblnk) begin
      err_blank += check_value("rgb", 32'(vga_pkg::col_black), 32'(rgb));
    end
    // First visit of each probed position
    for (k = 0; k < probe_h.size(); k++) begin
      if (!probe_hit[k] && hcount == probe_h[k] && vcount == probe_v[k]) begin
        probe_hit[k] = 1'b1;
        probe_errs[k] += check_value($sformatf("rgb at (%0d,%0d)", probe_h[k], probe_v[k]),
                                     32'(probe_rgb[k]), 32'(rgb));
      end
    end
    // Raster order, line wrap steps the line count
    if (exp_h == vga_pkg::h_total - 1'b1) begin
      exp_h = '0;
      if (exp_v == vga_pkg::v_total - 1'b1) begin
        exp_v = '0;
      end else begin
        exp_v = exp_v + 1'b1;
      end
    end else begin
      exp_h = exp_h + 1'b1;
    end
  endtask

  initial begin : main
    int k;
    int j;
    int tmp;
    int order[$];
    pclk = 1'b0;
    rst  = 1'b1;
    void'($urandom(32'h7535));
    load_probes();

    // Sixteen reset cycles, released on the last edge
    for (k = 0; k < 16; k++) begin
      @(posedge pclk);
      if (k == 15) begin
        rst <= 1'b0;
      end
      @(negedge pclk);
      err_reset += check_idle();
    end
    // First cycle out of reset, pipeline still empty
    @(negedge pclk);
    err_reset += check_idle();
    report_test("reset state", err_reset);

    // One full frame plus the wrap back to the first pixels
    exp_h = '0;
    exp_v = '0;
    for (k = 0; k < frame_len + 2; k++) begin
      @(negedge pclk);
      check_pixel();
    end
    report_test("counter sequence", err_count);
    report_test("sync and blanking", err_sync);
    report_test("blanking colour", err_blank);

    // Probe reports in shuffled order
    for (k = 0; k < probe_h.size(); k++) begin
      order.push_back(k);
    end
    for (k = order.size() - 1; k > 0; k--) begin
      j = $urandom % (k + 1);
      tmp = order[k];
      order[k] = order[j];
      order[j] = tmp;
    end
    foreach (order[i]) begin
      j = order[i];
      probe_errs[j] += check_true(probe_hit[j], $sformatf("probe (%0d,%0d) was never reached",
                                                          probe_h[j], probe_v[j]));
      report_test($sformatf("probe (%0d,%0d)", probe_h[j], probe_v[j]), probe_errs[j]);
    end

    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, error_total);
    if (tests_failed == 0 && error_total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: build.f
src/vga_pkg.sv
src/vga_if.sv
src/vga_timing.sv
src/draw_background.sv
src/draw_rect.sv
src/vga_top.sv
bench/vga_tb.sv

// File: Makefile
# Verilator flow for the SVGA test-pattern pipeline

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module vga_tb -f build.f

sim:
	verilator --binary --timing --assert --top-module vga_tb -f build.f
	@out="$$(./obj_dir/Vvga_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// File: bench/vga_stimulus.txt
# Pixel probes on the output stream, one per line
# Columns: hcount (decimal), vcount (decimal), expected rgb (hex)
# Frame edges and corners
0 0 ff0
799 0 ff0
400 0 ff0
0 599 f00
799 599 f00
400 599 f00
0 1 0f0
0 300 0f0
799 300 00f
799 598 00f
# Blanking regions
800 0 000
1055 300 000
0 600 000
400 627 000
# Letter bars and their boundaries
125 75 c61
124 75 888
125 74 888
375 125 c61
376 100 888
425 100 c61
675 525 c61
676 525 888
675 526 888
350 300 c61
324 300 888
150 450 c61
150 424 888
176 450 888
450 300 c61
476 300 888
600 300 888
# Default rectangle, inside, edges and just outside
200 250 0ac
299 309 0ac
299 250 0ac
200 309 0ac
250 280 0ac
199 250 888
300 250 888
250 249 888
250 310 888
